// ==== slide_pkg.sv ====
//////////////////////////////
// Slide unit geometry, opcode and width enums,
// instruction and result word structs
//////////////////////////////
`default_nettype none

package slide_pkg;

  //////////////////////////////
  // Geometry
  //////////////////////////////

  localparam int unsigned NrLanes          = 2;
  localparam int unsigned LaneBytes        = 8;
  // One result word spans all lanes
  localparam int unsigned WordBytes        = NrLanes * LaneBytes;
  localparam int unsigned MaxVlBytes       = 64;
  localparam int unsigned WordsPerReg      = 4;
  localparam int unsigned InsnQueueDepth   = 2;
  localparam int unsigned ResultQueueDepth = 2;

  //////////////////////////////
  // Enums and scalar types
  //////////////////////////////

  typedef enum logic {
    SLIDE_UP,
    SLIDE_DOWN
  } slide_op_e;

  // Encoding doubles as the byte shift of an element
  typedef enum logic [1:0] {
    EW8,
    EW16,
    EW32,
    EW64
  } sew_e;

  typedef logic [1:0]               vid_t;
  typedef logic [4:0]               vreg_t;
  // Register number times WordsPerReg plus word index
  typedef logic [6:0]               vaddr_t;
  typedef logic [8*WordBytes-1:0]   word_t;
  typedef logic [WordBytes-1:0]     strb_t;
  // Stride or vl as requested, in elements
  typedef logic [6:0]               elem_t;
  // Stride or vl after scaling to bytes
  typedef logic [9:0]               bcnt_t;

  // Queued instruction, stride and vl already in bytes
  typedef struct packed {
    slide_op_e op;
    sew_e      sew;
    bcnt_t     stride;
    bcnt_t     vl;
    vreg_t     vd;
    vid_t      id;
  } slide_insn_t;

  // One result word on its way to the lanes
  typedef struct packed {
    vid_t   id;
    vaddr_t addr;
    word_t  data;
    strb_t  be;
    logic   last;
  } result_t;

endpackage

`default_nettype wire

// ==== slide_result_if.sv ====
//////////////////////////////
// Result word handshake with queue status
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

interface slide_result_if import slide_pkg::*; ();

  // Word moves on an edge with valid and ready high
  logic    valid;
  logic    ready;
  result_t payload;
  // Occupancy of the result queue, always driven by the queue itself
  logic    full;
  logic    empty;

  // Sending side; the queue is the sender on the pop side
  modport prod (
    output valid, payload, full, empty,
    input  ready
  );

  // Receiving side; the queue is the receiver on the push side
  modport cons (
    input  valid, payload,
    output ready, full, empty
  );

endinterface

`default_nettype wire

// ==== slide_issue.sv ====
//////////////////////////////
// Instruction queue and slide engine
// Builds byte-enabled result words from operand words
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module slide_issue import slide_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  // Instruction request
  input  logic      req_valid_i,
  input  slide_op_e req_op_i,
  input  sew_e      req_sew_i,
  input  elem_t     req_stride_i,
  input  elem_t     req_vl_i,
  input  vreg_t     req_vd_i,
  input  vid_t      req_id_i,
  output logic      req_ready_o,
  // Source register words
  input  word_t     operand_i,
  input  logic      operand_valid_i,
  output logic      operand_ready_o,
  // Result words towards the queue
  slide_result_if.prod push_if
);

  localparam int unsigned PtrW  = $clog2(WordBytes);
  localparam int unsigned QPtrW = $clog2(InsnQueueDepth);
  localparam int unsigned WIdxW = $clog2(WordsPerReg);
  localparam logic [PtrW:0] FullWord = (PtrW+1)'(WordBytes);

  typedef enum logic {
    SLIDE_IDLE,
    SLIDE_RUN
  } slide_state_e;

  //////////////////////////////
  // Instruction queue
  //////////////////////////////

  slide_insn_t             insn_q [InsnQueueDepth];
  slide_insn_t             accept_insn;
  slide_insn_t             insn_cur;
  logic [QPtrW-1:0]        acc_ptr_q, iss_ptr_q;
  logic [QPtrW:0]          insn_cnt_q;
  logic                    accept;
  logic                    retire;

  assign req_ready_o = insn_cnt_q != (QPtrW+1)'(InsnQueueDepth);
  assign accept      = req_valid_i && req_ready_o;
  // Head entry stays put until its last word is pushed
  assign insn_cur    = insn_q[iss_ptr_q];

  // Scale stride and vl to bytes on the way in
  always_comb begin
    accept_insn.op     = req_op_i;
    accept_insn.sew    = req_sew_i;
    accept_insn.stride = bcnt_t'(req_stride_i) << req_sew_i;
    accept_insn.vl     = bcnt_t'(req_vl_i) << req_sew_i;
    accept_insn.vd     = req_vd_i;
    accept_insn.id     = req_id_i;
  end

  //////////////////////////////
  // Slide engine
  //////////////////////////////

  slide_state_e     state_q, state_d;
  // Byte pointers into the operand and into the word being built
  logic [PtrW-1:0]  in_pnt_q, in_pnt_d;
  logic [PtrW-1:0]  out_pnt_q, out_pnt_d;
  // Bytes still to be written for this instruction
  bcnt_t            cnt_q, cnt_d;
  logic [WIdxW-1:0] widx_q, widx_d;
  word_t            word_q, word_d, word_mrg;
  strb_t            be_q, be_d, be_mrg;

  logic [PtrW:0]    in_room, out_room, step;
  logic [PtrW:0]    in_sum, out_sum;
  logic             last_step, in_wrap, push_now, fire;

  // Bytes copied this cycle, bounded by both words and the count
  always_comb begin
    in_room  = FullWord - {1'b0, in_pnt_q};
    out_room = FullWord - {1'b0, out_pnt_q};
    step     = (in_room < out_room) ? in_room : out_room;
    if (cnt_q < bcnt_t'(step)) begin
      step = cnt_q[PtrW:0];
    end
  end

  assign in_sum    = {1'b0, in_pnt_q} + step;
  assign out_sum   = {1'b0, out_pnt_q} + step;
  assign last_step = cnt_q <= bcnt_t'(step);
  assign in_wrap   = in_sum == FullWord;
  assign push_now  = (out_sum == FullWord) || last_step;
  // Nothing moves while the queue cannot take a word
  assign fire      = (state_q == SLIDE_RUN) && operand_valid_i && push_if.ready;

  // Next operand only once the current one is used up
  assign operand_ready_o = (state_q == SLIDE_RUN) && push_if.ready && (in_wrap || last_step);

  // Merge the overlap of the operand into the word under construction
  always_comb begin
    int unsigned src;
    word_mrg = word_q;
    be_mrg   = be_q;
    src      = 0;
    for (int unsigned b = 0; b < WordBytes; b++) begin
      if (b >= out_pnt_q && b < out_pnt_q + step) begin
        src                = b - out_pnt_q + in_pnt_q;
        word_mrg[8*b +: 8] = operand_i[8*src +: 8];
        be_mrg[b]          = 1'b1;
      end
    end
  end

  // Push side
  assign push_if.valid        = (state_q == SLIDE_RUN) && operand_valid_i && push_now;
  assign push_if.payload.id   = insn_cur.id;
  assign push_if.payload.addr = vaddr_t'(int'(insn_cur.vd) * WordsPerReg + int'(widx_q));
  assign push_if.payload.data = word_mrg;
  assign push_if.payload.be   = be_mrg;
  assign push_if.payload.last = last_step;

  always_comb begin
    state_d   = state_q;
    in_pnt_d  = in_pnt_q;
    out_pnt_d = out_pnt_q;
    cnt_d     = cnt_q;
    widx_d    = widx_q;
    word_d    = word_q;
    be_d      = be_q;
    retire    = 1'b0;
    unique case (state_q)
      SLIDE_IDLE: begin
        if (insn_cnt_q != '0) begin
          state_d = SLIDE_RUN;
          word_d  = '0;
          be_d    = '0;
          if (insn_cur.op == SLIDE_UP) begin
            // Read from source byte 0, write from the stride on
            in_pnt_d  = '0;
            out_pnt_d = insn_cur.stride[PtrW-1:0];
            cnt_d     = insn_cur.vl - insn_cur.stride;
            widx_d    = insn_cur.stride[PtrW +: WIdxW];
          end else begin
            // Read from the stride on, write from byte 0
            in_pnt_d  = insn_cur.stride[PtrW-1:0];
            out_pnt_d = '0;
            cnt_d     = insn_cur.vl;
            widx_d    = '0;
          end
        end
      end
      SLIDE_RUN: begin
        if (fire) begin
          // A full word wraps the pointer back to 0
          in_pnt_d  = in_sum[PtrW-1:0];
          out_pnt_d = out_sum[PtrW-1:0];
          cnt_d     = cnt_q - bcnt_t'(step);
          word_d    = word_mrg;
          be_d      = be_mrg;
          if (push_now) begin
            word_d = '0;
            be_d   = '0;
            widx_d = widx_q + 1'b1;
          end
          if (last_step) begin
            state_d = SLIDE_IDLE;
            retire  = 1'b1;
          end
        end
      end
      default: state_d = SLIDE_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= SLIDE_IDLE;
      in_pnt_q   <= '0;
      out_pnt_q  <= '0;
      cnt_q      <= '0;
      widx_q     <= '0;
      acc_ptr_q  <= '0;
      iss_ptr_q  <= '0;
      insn_cnt_q <= '0;
    end else begin
      state_q   <= state_d;
      in_pnt_q  <= in_pnt_d;
      out_pnt_q <= out_pnt_d;
      cnt_q     <= cnt_d;
      widx_q    <= widx_d;
      if (accept) begin
        acc_ptr_q <= acc_ptr_q + 1'b1;
      end
      if (retire) begin
        iss_ptr_q <= iss_ptr_q + 1'b1;
      end
      unique case ({accept, retire})
        2'b10:   insn_cnt_q <= insn_cnt_q + 1'b1;
        2'b01:   insn_cnt_q <= insn_cnt_q - 1'b1;
        default: insn_cnt_q <= insn_cnt_q;
      endcase
    end
  end

  // Entry storage and the word under construction
  always_ff @(posedge clk_i) begin
    if (accept) begin
      insn_q[acc_ptr_q] <= accept_insn;
    end
    word_q <= word_d;
    be_q   <= be_d;
  end

endmodule

`default_nettype wire

// ==== slide_result_queue.sv ====
//////////////////////////////
// Two-entry result word FIFO
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module slide_result_queue import slide_pkg::*; (
  input  logic clk_i,
  input  logic rst_ni,
  slide_result_if.cons push_if,
  slide_result_if.prod pop_if
);

  localparam int unsigned PtrW = $clog2(ResultQueueDepth);

  result_t         mem_q [ResultQueueDepth];
  logic [PtrW-1:0] wr_ptr_q, rd_ptr_q;
  logic [PtrW:0]   cnt_q;
  logic            full, empty;
  logic            push, pop;

  assign full  = cnt_q == (PtrW+1)'(ResultQueueDepth);
  assign empty = cnt_q == '0;

  // Same status on both sides
  assign push_if.full  = full;
  assign push_if.empty = empty;
  assign pop_if.full   = full;
  assign pop_if.empty  = empty;

  assign push_if.ready = !full;
  // Head is registered, so a word shows up the cycle after its push
  assign pop_if.valid   = !empty;
  assign pop_if.payload = mem_q[rd_ptr_q];

  assign push = push_if.valid && push_if.ready;
  assign pop  = pop_if.valid && pop_if.ready;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      // Simultaneous push and pop leaves the count alone
      unique case ({push, pop})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= push_if.payload;
    end
  end

endmodule

`default_nettype wire

// ==== slide_commit.sv ====
//////////////////////////////
// Per-lane request and grant tracking, pop and done pulse
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module slide_commit import slide_pkg::*; (
  input  logic               clk_i,
  input  logic               rst_ni,
  slide_result_if.cons       pop_if,
  // Lane write port
  output logic [NrLanes-1:0] result_req_o,
  input  logic [NrLanes-1:0] result_gnt_i,
  output vaddr_t             result_addr_o,
  output vid_t               result_id_o,
  output word_t              result_wdata_o,
  output strb_t              result_be_o,
  // Instruction completion
  output logic               done_o,
  output vid_t               done_id_o
);

  // Lanes still to grant the current head
  logic [NrLanes-1:0] pending_q, pending, left;
  // Head already partly granted
  logic               active_q;

  // A fresh head requests every lane in its first cycle
  assign pending      = active_q ? pending_q : {NrLanes{pop_if.valid}};
  assign result_req_o = pending;
  assign left         = pending & ~result_gnt_i;

  // Pop once the last outstanding lane grants
  assign pop_if.ready = pop_if.valid && (left == '0);

  // Shared word fields straight from the queue head
  assign result_addr_o  = pop_if.payload.addr;
  assign result_id_o    = pop_if.payload.id;
  assign result_wdata_o = pop_if.payload.data;
  assign result_be_o    = pop_if.payload.be;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pending_q <= '0;
      active_q  <= 1'b0;
      done_o    <= 1'b0;
    end else begin
      pending_q <= left;
      active_q  <= pop_if.valid && (left != '0);
      // Last word of an instruction fully granted
      done_o    <= pop_if.ready && pop_if.payload.last;
    end
  end

  always_ff @(posedge clk_i) begin
    if (pop_if.ready) begin
      done_id_o <= pop_if.payload.id;
    end
  end

endmodule

`default_nettype wire

// ==== slide_unit.sv ====
//////////////////////////////
// Slide unit top level
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module slide_unit import slide_pkg::*; (
  input  logic               clk_i,
  input  logic               rst_ni,
  // Instruction request
  input  logic               req_valid_i,
  input  slide_op_e          req_op_i,
  input  sew_e               req_sew_i,
  input  elem_t              req_stride_i,
  input  elem_t              req_vl_i,
  input  vreg_t              req_vd_i,
  input  vid_t               req_id_i,
  output logic               req_ready_o,
  // Source register words
  input  word_t              operand_i,
  input  logic               operand_valid_i,
  output logic               operand_ready_o,
  // Lane write port, lane l owns bytes 8l to 8l+7
  output logic [NrLanes-1:0] result_req_o,
  input  logic [NrLanes-1:0] result_gnt_i,
  output vaddr_t             result_addr_o,
  output vid_t               result_id_o,
  output word_t              result_wdata_o,
  output strb_t              result_be_o,
  // Completion
  output logic               done_o,
  output vid_t               done_id_o
);

  // Engine to queue, queue to commit
  slide_result_if push_if ();
  slide_result_if pop_if ();

  slide_issue slide_issue_i (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .req_valid_i     (req_valid_i),
    .req_op_i        (req_op_i),
    .req_sew_i       (req_sew_i),
    .req_stride_i    (req_stride_i),
    .req_vl_i        (req_vl_i),
    .req_vd_i        (req_vd_i),
    .req_id_i        (req_id_i),
    .req_ready_o     (req_ready_o),
    .operand_i       (operand_i),
    .operand_valid_i (operand_valid_i),
    .operand_ready_o (operand_ready_o),
    .push_if         (push_if.prod)
  );

  slide_result_queue slide_result_queue_i (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_if (push_if.cons),
    .pop_if  (pop_if.prod)
  );

  slide_commit slide_commit_i (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .pop_if         (pop_if.cons),
    .result_req_o   (result_req_o),
    .result_gnt_i   (result_gnt_i),
    .result_addr_o  (result_addr_o),
    .result_id_o    (result_id_o),
    .result_wdata_o (result_wdata_o),
    .result_be_o    (result_be_o),
    .done_o         (done_o),
    .done_id_o      (done_id_o)
  );

endmodule

`default_nettype wire

// ==== tb_clk_gen.sv ====
//////////////////////////////
// Testbench clock and reset
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
  output logic clk_o,
  output logic rst_no
);

  // 100 ns period
  initial begin
    clk_o = 1'b0;
    forever #50 clk_o = ~clk_o;
  end

  // Reset held for five cycles, released on a falling edge
  initial begin
    rst_no = 1'b0;
    repeat (5) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

`default_nettype wire

// ==== tb_slide_assert.sv ====
//////////////////////////////
// Handshake assertions on the commit stage
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_slide_assert import slide_pkg::*; (
  input logic               clk_i,
  input logic               rst_ni,
  input logic [NrLanes-1:0] req_i,
  input logic [NrLanes-1:0] gnt_i,
  input word_t              wdata_i,
  input logic               done_i
);

  // A lane keeps requesting until it is granted
  for (genvar l = 0; l < NrLanes; l++) begin : g_lane
    req_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
      req_i[l] && !gnt_i[l] |=> req_i[l])
      else $error("lane %0d dropped its request before the grant", l);
  end

  // Done only in the cycle after a grant that finished a word
  done_after_grant: assert property (@(posedge clk_i) disable iff (!rst_ni)
    done_i |-> $past(req_i != '0 && (req_i & ~gnt_i) == '0))
    else $error("done pulse without a completing grant");

  // Shared write data holds while any lane still waits
  wdata_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (req_i & ~gnt_i) != '0 |=> $stable(wdata_i))
    else $error("write data changed while a request was pending");

endmodule

`default_nettype wire

// ==== tb_slide_checker.sv ====
//////////////////////////////
// Reference model of the slide rules
// Result, done and per-test reporting
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_slide_checker import slide_pkg::*; (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               req_valid_i,
  input  logic               req_ready_i,
  input  slide_op_e          req_op_i,
  input  sew_e               req_sew_i,
  input  elem_t              req_stride_i,
  input  elem_t              req_vl_i,
  input  vreg_t              req_vd_i,
  input  vid_t               req_id_i,
  input  word_t              operand_i,
  input  logic               operand_valid_i,
  input  logic               operand_ready_i,
  input  logic [NrLanes-1:0] result_req_i,
  input  logic [NrLanes-1:0] result_gnt_i,
  input  vaddr_t             result_addr_i,
  input  vid_t               result_id_i,
  input  word_t              result_wdata_i,
  input  strb_t              result_be_i,
  input  logic               done_i,
  input  vid_t               done_id_i,
  input  logic               finish_i,
  output int                 done_cnt_o,
  output int                 err_cnt_o
);

  // Accepted instructions, stride and vl in bytes
  logic       down_a [256];
  int         sew_a [256];
  int         sb_a [256];
  int         vb_a [256];
  int         vd_a [256];
  int         id_a [256];
  int         need_a [256];
  int         start_a [256];
  // Consumed source bytes, keyed by instruction times 256 plus byte
  logic [7:0] src_b [int];
  int         n_acc = 0;
  // Operand feed position and result position
  int         fi = 0, fk = 0, ci = 0, wi = 0;
  int         errs = 0, dones = 0, passed = 0, last_errs = 0;
  logic [NrLanes-1:0] granted = '0;
  logic       exp_done = 1'b0;
  int         exp_n = 0;

  assign done_cnt_o = dones;
  assign err_cnt_o  = errs;

  function automatic string test_name(input int n);
    return $sformatf("insn%0d_%s_ew%0d", n, down_a[n] ? "down" : "up", 8 << sew_a[n]);
  endfunction

  task automatic mismatch(input int n, input string what, input logic [127:0] exp_v,
                          input logic [127:0] act_v);
    errs++;
    $display("CHECK FAILED %s %s expected %h actual %h", test_name(n), what, exp_v, act_v);
  endtask

  // Expected bytes of word w straight from the slide rules
  function automatic void expect_word(input int n, input int w, output word_t d,
                                      output strb_t be);
    int i;
    int src;
    d  = '0;
    be = '0;
    for (int b = 0; b < WordBytes; b++) begin
      i = w * WordBytes + b;
      if (i < vb_a[n] && (down_a[n] || i >= sb_a[n])) begin
        src   = down_a[n] ? i + sb_a[n] : i - sb_a[n];
        be[b] = 1'b1;
        d[8*b +: 8] = src_b.exists(n * 256 + src) ? src_b[n * 256 + src] : 8'hxx;
      end
    end
  endfunction

  always @(posedge clk_i) begin : watch
    logic [NrLanes-1:0] hit;
    word_t  ed;
    word_t  msk;
    strb_t  eb;
    vaddr_t ea;
    int     first;
    if (rst_ni) begin
      //////////////////////////////
      // Done pulse owed from the previous edge
      //////////////////////////////
      if (done_i !== exp_done) begin
        errs++;
        $display("done pulse %s at an unexpected cycle", done_i ? "seen" : "missing");
      end else if (exp_done && done_id_i !== vid_t'(id_a[exp_n])) begin
        mismatch(exp_n, "done_id", 128'(id_a[exp_n]), 128'(done_id_i));
      end
      if (exp_done) begin
        if (fi <= exp_n) begin
          errs++;
          $display("%s finished before all its source words were consumed",
                   test_name(exp_n));
        end
        dones++;
        if (errs == last_errs) passed++;
        $display("test %s: %s", test_name(exp_n), (errs == last_errs) ? "ok" : "failed");
        last_errs = errs;
      end
      exp_done = 1'b0;

      // Acceptance, scaled by the element width
      if (req_valid_i && req_ready_i) begin
        down_a[n_acc] = (req_op_i == SLIDE_DOWN);
        sew_a[n_acc]  = int'(req_sew_i);
        sb_a[n_acc]   = int'(req_stride_i) << int'(req_sew_i);
        vb_a[n_acc]   = int'(req_vl_i) << int'(req_sew_i);
        vd_a[n_acc]   = int'(req_vd_i);
        id_a[n_acc]   = int'(req_id_i);
        if (req_op_i == SLIDE_UP) begin
          start_a[n_acc] = 0;
          need_a[n_acc]  = (vb_a[n_acc] - sb_a[n_acc] + WordBytes - 1) / WordBytes;
        end else begin
          start_a[n_acc] = sb_a[n_acc] / WordBytes;
          need_a[n_acc]  = (sb_a[n_acc] % WordBytes + vb_a[n_acc] + WordBytes - 1) / WordBytes;
        end
        n_acc++;
      end

      // Operand words land at their place in the source register
      if (operand_valid_i && operand_ready_i) begin
        for (int b = 0; b < WordBytes; b++) begin
          src_b[fi * 256 + (start_a[fi] + fk) * WordBytes + b] = operand_i[8*b +: 8];
        end
        fk++;
        if (fk == need_a[fi]) begin
          fi++;
          fk = 0;
        end
      end

      //////////////////////////////
      // Result words, complete once every lane granted
      //////////////////////////////
      hit = result_req_i & result_gnt_i;
      if ((hit & granted) != '0) begin
        errs++;
        $display("a lane was granted twice for one result word");
      end
      granted = granted | hit;
      if (granted == {NrLanes{1'b1}}) begin
        granted = '0;
        if (ci >= n_acc) begin
          errs++;
          $display("result word seen with no instruction outstanding");
        end else begin
          first = down_a[ci] ? 0 : sb_a[ci] / WordBytes;
          ea    = vaddr_t'(vd_a[ci] * WordsPerReg + first + wi);
          expect_word(ci, first + wi, ed, eb);
          for (int b = 0; b < WordBytes; b++) begin
            msk[8*b +: 8] = {8{eb[b]}};
          end
          if (result_addr_i !== ea) mismatch(ci, "addr", 128'(ea), 128'(result_addr_i));
          if (result_id_i !== vid_t'(id_a[ci])) begin
            mismatch(ci, "id", 128'(id_a[ci]), 128'(result_id_i));
          end
          if (result_be_i !== eb) mismatch(ci, "be", 128'(eb), 128'(result_be_i));
          if ((result_wdata_i & msk) !== ed) begin
            mismatch(ci, "data", ed, result_wdata_i & msk);
          end
          if ((first + wi + 1) * WordBytes >= vb_a[ci]) begin
            exp_done = 1'b1;
            exp_n    = ci;
            ci++;
            wi = 0;
          end else begin
            wi++;
          end
        end
      end

      if (finish_i) begin
        if (fi != n_acc || fk != 0) begin
          errs++;
          $display("source words consumed do not match the accepted instructions");
        end
        if (ci != n_acc) begin
          errs++;
          $display("not every expected result word was seen");
        end
        $display("summary: %0d tests, %0d passed, %0d failed, %0d errors",
                 dones, passed, dones - passed, errs);
      end
    end
  end

endmodule

`default_nettype wire

// ==== tb_slide_unit.sv ====
//////////////////////////////
// Slide unit testbench top
// Random drivers, timeout and final status
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_slide_unit import slide_pkg::*; ();

  localparam int NumInsns    = 40;
  localparam int LimitCycles = 40 * NumInsns + 100;

  logic               clk_i, rst_ni;
  logic               req_valid_i, req_ready_o;
  slide_op_e          req_op_i;
  sew_e               req_sew_i;
  elem_t              req_stride_i, req_vl_i;
  vreg_t              req_vd_i;
  vid_t               req_id_i;
  word_t              operand_i;
  logic               operand_valid_i, operand_ready_o;
  logic [NrLanes-1:0] result_req_o, result_gnt_i;
  vaddr_t             result_addr_o;
  vid_t               result_id_o, done_id_o;
  word_t              result_wdata_o;
  strb_t              result_be_o;
  logic               done_o;

  int   seed = 59996;
  // Source word count per accepted instruction, for the operand driver
  int   need_q[$];
  logic finish = 1'b0;
  int   done_cnt, err_cnt;
  int   cycles = 0;

  tb_clk_gen clk_gen_i (.clk_o(clk_i), .rst_no(rst_ni));

  slide_unit slide_unit_i (.*);

  tb_slide_checker slide_checker_i (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .req_valid_i     (req_valid_i),
    .req_ready_i     (req_ready_o),
    .req_op_i        (req_op_i),
    .req_sew_i       (req_sew_i),
    .req_stride_i    (req_stride_i),
    .req_vl_i        (req_vl_i),
    .req_vd_i        (req_vd_i),
    .req_id_i        (req_id_i),
    .operand_i       (operand_i),
    .operand_valid_i (operand_valid_i),
    .operand_ready_i (operand_ready_o),
    .result_req_i    (result_req_o),
    .result_gnt_i    (result_gnt_i),
    .result_addr_i   (result_addr_o),
    .result_id_i     (result_id_o),
    .result_wdata_i  (result_wdata_o),
    .result_be_i     (result_be_o),
    .done_i          (done_o),
    .done_id_i       (done_id_o),
    .finish_i        (finish),
    .done_cnt_o      (done_cnt),
    .err_cnt_o       (err_cnt)
  );

  bind slide_commit tb_slide_assert slide_commit_assert_i (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .req_i   (result_req_o),
    .gnt_i   (result_gnt_i),
    .wdata_i (result_wdata_o),
    .done_i  (done_o)
  );

  //////////////////////////////
  // Instruction driver
  //////////////////////////////
  initial begin : drive_insns
    int sb;
    int vb;
    int maxel;
    int gap;
    req_valid_i  = 1'b0;
    req_op_i     = SLIDE_UP;
    req_sew_i    = EW8;
    req_stride_i = '0;
    req_vl_i     = '0;
    req_vd_i     = '0;
    req_id_i     = '0;
    @(posedge rst_ni);
    @(negedge clk_i);
    for (int n = 0; n < NumInsns; n++) begin
      gap = {$random(seed)} % 3;
      repeat (gap) begin
        req_valid_i = 1'b0;
        @(negedge clk_i);
      end
      req_op_i  = ($random(seed) & 1) ? SLIDE_DOWN : SLIDE_UP;
      req_sew_i = sew_e'({$random(seed)} % 4);
      // Vl stays within MaxVlBytes once scaled
      maxel     = MaxVlBytes >> int'(req_sew_i);
      req_vl_i  = elem_t'(1 + {$random(seed)} % maxel);
      if (req_op_i == SLIDE_UP) begin
        req_stride_i = elem_t'({$random(seed)} % int'(req_vl_i));
      end else begin
        req_stride_i = elem_t'({$random(seed)} % maxel);
      end
      req_vd_i    = vreg_t'($random(seed));
      req_id_i    = vid_t'($random(seed));
      req_valid_i = 1'b1;
      sb = int'(req_stride_i) << int'(req_sew_i);
      vb = int'(req_vl_i) << int'(req_sew_i);
      while (!req_ready_o) @(negedge clk_i);
      if (req_op_i == SLIDE_UP) begin
        need_q.push_back((vb - sb + WordBytes - 1) / WordBytes);
      end else begin
        need_q.push_back((sb % WordBytes + vb + WordBytes - 1) / WordBytes);
      end
      @(negedge clk_i);
    end
    req_valid_i = 1'b0;
  end

  // Operand driver, one random source word at a time with idle gaps
  initial begin : drive_operands
    int need;
    int gap;
    operand_valid_i = 1'b0;
    operand_i       = '0;
    @(posedge rst_ni);
    @(negedge clk_i);
    forever begin
      if (need_q.size() == 0) begin
        operand_valid_i = 1'b0;
        @(negedge clk_i);
      end else begin
        need = need_q.pop_front();
        for (int w = 0; w < need; w++) begin
          gap = ({$random(seed)} % 4 == 0) ? 1 + {$random(seed)} % 2 : 0;
          repeat (gap) begin
            operand_valid_i = 1'b0;
            @(negedge clk_i);
          end
          for (int b = 0; b < WordBytes; b++) begin
            operand_i[8*b +: 8] = 8'($random(seed));
          end
          operand_valid_i = 1'b1;
          while (!operand_ready_o) @(negedge clk_i);
          @(negedge clk_i);
        end
        operand_valid_i = 1'b0;
      end
    end
  end

  // Each lane grants about three cycles in four
  initial begin : drive_grants
    result_gnt_i = '0;
    @(posedge rst_ni);
    forever begin
      @(negedge clk_i);
      result_gnt_i = NrLanes'($random(seed)) | NrLanes'($random(seed));
    end
  end

  //////////////////////////////
  // Timeout and end of run
  //////////////////////////////
  always @(posedge clk_i) begin
    cycles = cycles + 1;
    if (cycles >= LimitCycles) begin
      $display("timeout: only %0d of %0d instructions done after %0d cycles",
               done_cnt, NumInsns, cycles);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  initial begin : run_end
    while (done_cnt < NumInsns) @(negedge clk_i);
    // Drain so a stray done pulse is still caught
    repeat (3) @(negedge clk_i);
    finish = 1'b1;
    @(negedge clk_i);
    finish = 1'b0;
    if (err_cnt == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== flist.f ====
slide_pkg.sv
slide_result_if.sv
slide_issue.sv
slide_result_queue.sv
slide_commit.sv
slide_unit.sv
tb_clk_gen.sv
tb_slide_assert.sv
tb_slide_checker.sv
tb_slide_unit.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the slide unit testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_slide_unit \
  -f flist.f -o sim && ./obj_dir/sim > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log
grep -q "STATUS: FAIL" sim.log && exit 1
grep -q "STATUS: PASS" sim.log || exit 1
